// File: common/rs_pkg.sv
package rs_pkg;

    // ==============================
    // Sizes
    // ==============================

    localparam int RS_DEPTH     = 16;
    localparam int ISSUE_WIDTH  = 3;
    localparam int PR_BITS      = 6;
    localparam int ROB_BITS     = 5;
    localparam int FUQ_DEPTH    = 8;

    // Queue pointer and occupancy widths, derived from the depth
    localparam int FUQ_PTR_BITS = $clog2(FUQ_DEPTH);
    localparam int FUQ_CNT_BITS = $clog2(FUQ_DEPTH + 1);

    // ==============================
    // Encodings
    // ==============================

    typedef enum logic [1:0] {
        fu_alu    = 2'd0,
        fu_ls     = 2'd1,
        fu_mult   = 2'd2,
        fu_branch = 2'd3
    } fu_kind_e;

    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_and   = 4'd2,
        op_or    = 4'd3,
        op_xor   = 4'd4,
        op_slt   = 4'd5,
        op_load  = 4'd6,
        op_store = 4'd7,
        op_mul   = 4'd8,
        op_mulh  = 4'd9,
        op_beq   = 4'd10,
        op_bne   = 4'd11
    } op_e;

    // ==============================
    // Packets
    // ==============================

    // Dispatched instruction, also the stored station entry
    typedef struct packed {
        logic                valid;
        fu_kind_e            fu_sel;
        op_e                 op_sel;
        logic [31:0]         pc;
        logic [PR_BITS-1:0]  dest_pr;
        logic [PR_BITS-1:0]  reg1_pr;
        logic                reg1_ready;
        logic [PR_BITS-1:0]  reg2_pr;
        logic                reg2_ready;
        logic [ROB_BITS-1:0] rob_entry;
    } rs_entry_t;

    // Issued instruction, ready bits no longer needed
    typedef struct packed {
        logic                valid;
        fu_kind_e            fu_sel;
        op_e                 op_sel;
        logic [31:0]         pc;
        logic [PR_BITS-1:0]  dest_pr;
        logic [PR_BITS-1:0]  reg1_pr;
        logic [PR_BITS-1:0]  reg2_pr;
        logic [ROB_BITS-1:0] rob_entry;
    } issue_packet_t;

    // Three result tags on the common data bus, one valid bit each
    typedef struct packed {
        logic [ISSUE_WIDTH-1:0]              valid;
        logic [ISSUE_WIDTH-1:0][PR_BITS-1:0] tag;
    } cdb_tags_t;

    // Queue nearly full, one bit per unit kind
    typedef struct packed {
        logic alu;
        logic ls;
        logic mult;
        logic branch;
    } fu_stall_t;

endpackage

// File: hw/priority_select.sv
`timescale 1ns/10ps

module priority_select (
    input  logic [rs_pkg::RS_DEPTH-1:0] req,
    output logic [rs_pkg::RS_DEPTH-1:0] gnt,
    output logic                        any
);
    import rs_pkg::*;

    // Set once a lower index has already requested
    logic seen;

    always_comb begin
        seen = 1'b0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            gnt[i] = req[i] & ~seen;
            seen   = seen | req[i];
        end
    end

    assign any = |req;

endmodule

// File: rs/rs.sv
`timescale 1ns/10ps

module rs (
    input  logic                                           clock,
    input  logic                                           reset,
    input  rs_pkg::rs_entry_t     [rs_pkg::ISSUE_WIDTH-1:0] rs_in,
    input  rs_pkg::cdb_tags_t                              cdb,
    input  rs_pkg::fu_stall_t                              fu_stall,
    output rs_pkg::issue_packet_t [rs_pkg::ISSUE_WIDTH-1:0] issue_insts,
    output logic                  [rs_pkg::ISSUE_WIDTH-1:0] struct_stall
);
    import rs_pkg::*;

    rs_entry_t [RS_DEPTH-1:0] entries;
    rs_entry_t [RS_DEPTH-1:0] entries_next;

    // Dispatched instructions after same-cycle wakeup
    rs_entry_t [ISSUE_WIDTH-1:0] incoming;

    logic [RS_DEPTH-1:0] free_mask;
    logic [ISSUE_WIDTH-1:0][RS_DEPTH-1:0] alloc_req;
    logic [ISSUE_WIDTH-1:0][RS_DEPTH-1:0] alloc_gnt;
    logic [ISSUE_WIDTH-1:0] alloc_any;

    logic [RS_DEPTH-1:0] src1_ok;
    logic [RS_DEPTH-1:0] src2_ok;
    logic [RS_DEPTH-1:0] ready_mask;
    logic [RS_DEPTH-1:0] issue_mask;
    logic [ISSUE_WIDTH-1:0][RS_DEPTH-1:0] issue_req;
    logic [ISSUE_WIDTH-1:0][RS_DEPTH-1:0] issue_gnt;

    // True when a valid CDB tag names this register
    function automatic logic tag_hit(input cdb_tags_t bus, input logic [PR_BITS-1:0] pr);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            if (bus.valid[k] && bus.tag[k] == pr) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic logic kind_stalled(input fu_kind_e kind, input fu_stall_t st);
        logic stalled;
        case (kind)
            fu_alu:  stalled = st.alu;
            fu_ls:   stalled = st.ls;
            fu_mult: stalled = st.mult;
            default: stalled = st.branch;
        endcase
        return stalled;
    endfunction

    function automatic issue_packet_t to_packet(input rs_entry_t e);
        issue_packet_t p;
        p.valid     = e.valid;
        p.fu_sel    = e.fu_sel;
        p.op_sel    = e.op_sel;
        p.pc        = e.pc;
        p.dest_pr   = e.dest_pr;
        p.reg1_pr   = e.reg1_pr;
        p.reg2_pr   = e.reg2_pr;
        p.rob_entry = e.rob_entry;
        return p;
    endfunction

    // ==============================
    // Allocation
    // ==============================

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            free_mask[i] = ~entries[i].valid;
        end
    end

    // Slot 2 takes the lowest free entry, then slot 1, then slot 0
    for (genvar s = 0; s < ISSUE_WIDTH; s++) begin : g_alloc
        if (s == ISSUE_WIDTH - 1) begin : g_first
            assign alloc_req[s] = free_mask;
        end else begin : g_next
            assign alloc_req[s] = alloc_req[s+1] & ~alloc_gnt[s+1];
        end
        priority_select u_alloc_sel (
            .req (alloc_req[s]),
            .gnt (alloc_gnt[s]),
            .any (alloc_any[s])
        );
    end

    assign struct_stall = ~alloc_any;

    // A tag on the bus this cycle also wakes a source being dispatched
    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            incoming[s] = rs_in[s];
            incoming[s].reg1_ready = rs_in[s].reg1_ready | tag_hit(cdb, rs_in[s].reg1_pr);
            incoming[s].reg2_ready = rs_in[s].reg2_ready | tag_hit(cdb, rs_in[s].reg2_pr);
        end
    end

    // ==============================
    // Wakeup and select
    // ==============================

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            src1_ok[i]    = entries[i].reg1_ready | tag_hit(cdb, entries[i].reg1_pr);
            src2_ok[i]    = entries[i].reg2_ready | tag_hit(cdb, entries[i].reg2_pr);
            ready_mask[i] = entries[i].valid & src1_ok[i] & src2_ok[i]
                          & ~kind_stalled(entries[i].fu_sel, fu_stall);
        end
    end

    for (genvar s = 0; s < ISSUE_WIDTH; s++) begin : g_issue
        if (s == ISSUE_WIDTH - 1) begin : g_first
            assign issue_req[s] = ready_mask;
        end else begin : g_next
            assign issue_req[s] = issue_req[s+1] & ~issue_gnt[s+1];
        end
        priority_select u_issue_sel (
            .req (issue_req[s]),
            .gnt (issue_gnt[s]),
            .any ()
        );
    end

    // Grants are one-hot, so at most one entry lands in each slot
    always_comb begin
        issue_insts = '0;
        issue_mask  = '0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            issue_mask = issue_mask | issue_gnt[s];
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (issue_gnt[s][i]) begin
                    issue_insts[s] = to_packet(entries[i]);
                end
            end
        end
    end

    // ==============================
    // Entry update
    // ==============================

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            entries_next[i]            = entries[i];
            entries_next[i].reg1_ready = src1_ok[i];
            entries_next[i].reg2_ready = src2_ok[i];
            if (issue_mask[i]) begin
                entries_next[i].valid = 1'b0;
            end
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                if (alloc_gnt[s][i] && rs_in[s].valid) begin
                    entries_next[i] = incoming[s];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            entries <= entries_next;
        end
    end

endmodule

// File: hw/fu_queue.sv
`timescale 1ns/10ps

module fu_queue #(
    parameter rs_pkg::fu_kind_e kind = rs_pkg::fu_alu
) (
    input  logic                                           clock,
    input  logic                                           reset,
    input  rs_pkg::issue_packet_t [rs_pkg::ISSUE_WIDTH-1:0] issue_insts,
    input  logic                                           pop,
    output rs_pkg::issue_packet_t                          head,
    output logic                                           almost_full
);
    import rs_pkg::*;

    issue_packet_t [FUQ_DEPTH-1:0] slots;

    logic [FUQ_PTR_BITS-1:0] head_ptr;
    logic [FUQ_PTR_BITS-1:0] tail_ptr;
    logic [FUQ_CNT_BITS-1:0] count;
    logic [FUQ_CNT_BITS-1:0] write_count;

    logic [ISSUE_WIDTH-1:0] match;
    logic [ISSUE_WIDTH-1:0][FUQ_PTR_BITS-1:0] wr_ptr;
    logic do_pop;

    // Keep only valid packets meant for this unit
    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            match[s] = issue_insts[s].valid && (issue_insts[s].fu_sel == kind);
        end
    end

    // Matching slots fill consecutive positions, slot 2 first
    always_comb begin
        write_count = '0;
        for (int s = ISSUE_WIDTH - 1; s >= 0; s--) begin
            wr_ptr[s]   = tail_ptr + write_count[FUQ_PTR_BITS-1:0];
            write_count = write_count + FUQ_CNT_BITS'(match[s]);
        end
    end

    assign head   = (count != '0) ? slots[head_ptr] : '0;
    assign do_pop = pop && head.valid;

    // Fewer than one full issue group of room left
    assign almost_full = count > FUQ_CNT_BITS'(FUQ_DEPTH - ISSUE_WIDTH);

    // ==============================
    // Pointers and storage
    // ==============================

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            head_ptr <= head_ptr + FUQ_PTR_BITS'(do_pop);
            tail_ptr <= tail_ptr + write_count[FUQ_PTR_BITS-1:0];
            count    <= count + write_count - FUQ_CNT_BITS'(do_pop);
        end
    end

    always_ff @(posedge clock) begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            if (match[s]) begin
                slots[wr_ptr[s]] <= issue_insts[s];
            end
        end
    end

endmodule

// File: hw/issue_stage.sv
`timescale 1ns/10ps

module issue_stage (
    input  logic                                           clock,
    input  logic                                           reset,
    input  rs_pkg::rs_entry_t     [rs_pkg::ISSUE_WIDTH-1:0] rs_in,
    input  rs_pkg::cdb_tags_t                              cdb,
    output logic                  [rs_pkg::ISSUE_WIDTH-1:0] struct_stall,
    input  logic                                           alu_pop,
    output rs_pkg::issue_packet_t                          alu_head,
    input  logic                                           ls_pop,
    output rs_pkg::issue_packet_t                          ls_head,
    input  logic                                           mult_pop,
    output rs_pkg::issue_packet_t                          mult_head,
    input  logic                                           branch_pop,
    output rs_pkg::issue_packet_t                          branch_head
);
    import rs_pkg::*;

    issue_packet_t [ISSUE_WIDTH-1:0] issue_insts;
    fu_stall_t                       fu_stall;

    rs u_rs (
        .clock        (clock),
        .reset        (reset),
        .rs_in        (rs_in),
        .cdb          (cdb),
        .fu_stall     (fu_stall),
        .issue_insts  (issue_insts),
        .struct_stall (struct_stall)
    );

    // One queue per unit kind, all fed by the same issue slots
    fu_queue #(.kind(fu_alu)) u_alu_q (
        .clock       (clock),
        .reset       (reset),
        .issue_insts (issue_insts),
        .pop         (alu_pop),
        .head        (alu_head),
        .almost_full (fu_stall.alu)
    );

    fu_queue #(.kind(fu_ls)) u_ls_q (
        .clock       (clock),
        .reset       (reset),
        .issue_insts (issue_insts),
        .pop         (ls_pop),
        .head        (ls_head),
        .almost_full (fu_stall.ls)
    );

    fu_queue #(.kind(fu_mult)) u_mult_q (
        .clock       (clock),
        .reset       (reset),
        .issue_insts (issue_insts),
        .pop         (mult_pop),
        .head        (mult_head),
        .almost_full (fu_stall.mult)
    );

    fu_queue #(.kind(fu_branch)) u_branch_q (
        .clock       (clock),
        .reset       (reset),
        .issue_insts (issue_insts),
        .pop         (branch_pop),
        .head        (branch_head),
        .almost_full (fu_stall.branch)
    );

endmodule

// File: sim/issue_stage_tb.sv
`timescale 1ns/10ps

module issue_stage_tb;
    import rs_pkg::*;

    localparam int ROB_COUNT    = 2 ** ROB_BITS;
    localparam int RANDOM_INSTS = 300;
    localparam int STIM_CYCLES  = 10 + 100 + 100 + 100 + RANDOM_INSTS * 4;
    localparam int DRAIN_CYCLES = 2000;
    localparam int WATCHDOG_NS  = (STIM_CYCLES + DRAIN_CYCLES) * 8;

    logic                                  clock;
    logic                                  reset;
    rs_entry_t [ISSUE_WIDTH-1:0]           rs_in;
    cdb_tags_t                             cdb;
    logic      [ISSUE_WIDTH-1:0]           struct_stall;
    logic                                  alu_pop;
    logic                                  ls_pop;
    logic                                  mult_pop;
    logic                                  branch_pop;
    issue_packet_t                         alu_head;
    issue_packet_t                         ls_head;
    issue_packet_t                         mult_head;
    issue_packet_t                         branch_head;

    // Scoreboard indexed by rob_entry
    rs_entry_t sent [ROB_COUNT];
    bit        in_use [ROB_COUNT];
    bit        accepted [ROB_COUNT];
    bit        need1 [ROB_COUNT];
    bit        need2 [ROB_COUNT];
    int        snap1 [ROB_COUNT];
    int        snap2 [ROB_COUNT];
    int        bcast_cnt [2 ** PR_BITS];
    int        left_kind [4];

    rs_entry_t                   send_q [$];
    logic [PR_BITS-1:0]          wake_q [$];
    rs_entry_t [ISSUE_WIDTH-1:0] driven;
    logic [ROB_BITS-1:0]         rob_next;

    int n_live;
    int n_accepted;
    int n_drained;
    int occ;
    bit count_occ;
    bit bcast_on;
    bit pop_random;
    bit hold_mult;

    always #4 clock = ~clock;

    issue_stage UUT (
        .clock        (clock),
        .reset        (reset),
        .rs_in        (rs_in),
        .cdb          (cdb),
        .struct_stall (struct_stall),
        .alu_pop      (alu_pop),
        .alu_head     (alu_head),
        .ls_pop       (ls_pop),
        .ls_head      (ls_head),
        .mult_pop     (mult_pop),
        .mult_head    (mult_head),
        .branch_pop   (branch_pop),
        .branch_head  (branch_head)
    );

    // ==============================
    // Reference and compare tasks
    // ==============================

    function automatic issue_packet_t expected_issue(input rs_entry_t e);
        issue_packet_t p;
        p.valid     = e.valid;
        p.fu_sel    = e.fu_sel;
        p.op_sel    = e.op_sel;
        p.pc        = e.pc;
        p.dest_pr   = e.dest_pr;
        p.reg1_pr   = e.reg1_pr;
        p.reg2_pr   = e.reg2_pr;
        p.rob_entry = e.rob_entry;
        return p;
    endfunction

    // Slot 2 needs one free entry, slot 1 two, slot 0 three
    function automatic logic [ISSUE_WIDTH-1:0] stall_for(input int used);
        int free_n;
        free_n = RS_DEPTH - used;
        return {free_n < 1, free_n < 2, free_n < 3};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("[ERROR] %0t: %s", $time, msg));
    endtask

    task automatic check_packet(input issue_packet_t got, input issue_packet_t exp);
        if (got !== exp) begin
            report_error($sformatf("packet got %h expected %h", got, exp));
        end
    endtask

    task automatic check_kind(input fu_kind_e got, input fu_kind_e exp);
        if (got !== exp) begin
            report_error($sformatf("kind %0d at the head of the %s queue", got, exp.name()));
        end
    endtask

    task automatic check_stall(input logic [ISSUE_WIDTH-1:0] got,
                               input logic [ISSUE_WIDTH-1:0] exp);
        if (got !== exp) begin
            report_error($sformatf("struct_stall %b expected %b", got, exp));
        end
    endtask

    task automatic retire(input fu_kind_e kind, input issue_packet_t head, input logic pop);
        logic [ROB_BITS-1:0] rob;
        if (head.valid === 1'b1 && pop === 1'b1) begin
            rob = head.rob_entry;
            check_kind(head.fu_sel, kind);
            if (!accepted[rob]) begin
                report_error($sformatf("rob %0d drained but not outstanding", rob));
            end
            check_packet(head, expected_issue(sent[rob]));
            if ((need1[rob] && bcast_cnt[sent[rob].reg1_pr] == snap1[rob])
                || (need2[rob] && bcast_cnt[sent[rob].reg2_pr] == snap2[rob])) begin
                report_error($sformatf("rob %0d issued before its source tag", rob));
            end
            accepted[rob] = 1'b0;
            in_use[rob]   = 1'b0;
            n_live--;
            n_drained++;
            left_kind[int'(kind)]--;
        end
    endtask

    // Heads and pops seen here are the values of the cycle that just ended
    always @(posedge clock) begin
        if (!reset) begin
            retire(fu_alu, alu_head, alu_pop);
            retire(fu_ls, ls_head, ls_pop);
            retire(fu_mult, mult_head, mult_pop);
            retire(fu_branch, branch_head, branch_pop);
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    task automatic step();
        rs_entry_t [ISSUE_WIDTH-1:0] next_slots;
        cdb_tags_t                   next_cdb;
        @(posedge clock);
        if (count_occ) begin
            check_stall(struct_stall, stall_for(occ));
        end
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            if (driven[s].valid && !struct_stall[s]) begin
                accepted[driven[s].rob_entry] = 1'b1;
                n_accepted++;
                occ++;
                if (!driven[s].reg1_ready) wake_q.push_back(driven[s].reg1_pr);
                if (!driven[s].reg2_ready) wake_q.push_back(driven[s].reg2_pr);
            end else if (driven[s].valid) begin
                send_q.push_front(driven[s]);
            end
        end
        next_slots = '0;
        for (int s = ISSUE_WIDTH - 1; s >= 0; s--) begin
            if (send_q.size() > 0) next_slots[s] = send_q.pop_front();
        end
        next_cdb = '0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            if (bcast_on && wake_q.size() > 0 && $urandom % 3 != 0) begin
                next_cdb.valid[k] = 1'b1;
                next_cdb.tag[k]   = wake_q.pop_front();
                bcast_cnt[next_cdb.tag[k]]++;
            end
        end
        driven     = next_slots;
        rs_in      <= next_slots;
        cdb        <= next_cdb;
        alu_pop    <= !pop_random || ($urandom % 4 != 0);
        ls_pop     <= !pop_random || ($urandom % 4 != 0);
        mult_pop   <= !hold_mult && (!pop_random || ($urandom % 4 != 0));
        branch_pop <= !pop_random || ($urandom % 4 != 0);
    endtask

    task automatic create(input fu_kind_e kind, input bit wait1, input bit wait2);
        rs_entry_t e;
        while (in_use[rob_next]) begin
            rob_next++;
            if (n_live == ROB_COUNT) step();
        end
        e.valid  = 1'b1;
        e.fu_sel = kind;
        case (kind)
            fu_alu:  e.op_sel = op_e'(4'($urandom_range(5)));
            fu_ls:   e.op_sel = ($urandom % 2) ? op_load : op_store;
            fu_mult: e.op_sel = ($urandom % 2) ? op_mul : op_mulh;
            default: e.op_sel = ($urandom % 2) ? op_beq : op_bne;
        endcase
        e.pc         = $urandom;
        e.dest_pr    = PR_BITS'($urandom);
        e.reg1_pr    = PR_BITS'($urandom);
        e.reg1_ready = !wait1;
        e.reg2_pr    = PR_BITS'($urandom);
        e.reg2_ready = !wait2;
        e.rob_entry  = rob_next;
        sent[rob_next]   = e;
        in_use[rob_next] = 1'b1;
        need1[rob_next]  = wait1;
        need2[rob_next]  = wait2;
        snap1[rob_next]  = bcast_cnt[e.reg1_pr];
        snap2[rob_next]  = bcast_cnt[e.reg2_pr];
        n_live++;
        left_kind[int'(kind)]++;
        send_q.push_back(e);
        rob_next++;
    endtask

    task automatic drain();
        while (n_live != 0) step();
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("Run timed out before every instruction drained");
    end

    initial begin
        void'($urandom(32'hd592));
        clock      = 1'b0;
        reset      = 1'b1;
        rs_in      = '0;
        cdb        = '0;
        alu_pop    = 1'b0;
        ls_pop     = 1'b0;
        mult_pop   = 1'b0;
        branch_pop = 1'b0;
        driven     = '0;
        rob_next   = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        check_stall(struct_stall, '0);
        if (alu_head.valid || ls_head.valid || mult_head.valid || branch_head.valid) begin
            report_error("a queue head is valid after reset");
        end

        // Ready instructions of every kind
        for (int i = 0; i < 12; i++) create(fu_kind_e'(2'(i)), 1'b0, 1'b0);
        drain();

        // Fill the station with waiting instructions and no broadcasts
        occ       = 0;
        count_occ = 1'b1;
        for (int i = 0; i < 20; i++) create(fu_kind_e'(2'($urandom)), 1'b1, $urandom % 2);
        repeat (12) step();
        if (occ != RS_DEPTH) begin
            report_error($sformatf("%0d entries occupied in a station that should be full", occ));
        end
        count_occ = 1'b0;
        bcast_on  = 1'b1;
        drain();

        // Multiply queue held while other kinds keep flowing
        hold_mult = 1'b1;
        for (int i = 0; i < 12; i++) create(fu_mult, 1'b0, 1'b0);
        for (int i = 0; i < 9; i++) create((i % 3 == 2) ? fu_branch : fu_kind_e'(2'(i % 3)), 0, 0);
        while (n_live != left_kind[int'(fu_mult)]) step();
        repeat (10) step();
        if (!mult_head.valid) begin
            report_error("multiply queue head is empty while its pop is held");
        end
        check_kind(mult_head.fu_sel, fu_mult);
        check_packet(mult_head, expected_issue(sent[mult_head.rob_entry]));
        hold_mult = 1'b0;
        drain();

        // ==============================
        // Random mix
        // ==============================
        pop_random = 1'b1;
        for (int n = 0; n < RANDOM_INSTS; n++) begin
            create(fu_kind_e'(2'($urandom)), $urandom % 4 == 0, $urandom % 4 == 0);
            if ($urandom % 2) step();
        end
        drain();

        if (n_drained == n_accepted) begin
            $display("test passed");
            $finish;
        end else begin
            report_error($sformatf("%0d drained, %0d accepted", n_drained, n_accepted));
        end
    end

endmodule

// File: src.f
common/rs_pkg.sv
hw/priority_select.sv
rs/rs.sv
hw/fu_queue.sv
hw/issue_stage.sv
sim/issue_stage_tb.sv
